// File: rtl/ahbPkg.sv
package ahbPkg;

  ////////////////////
  // Transfer types
  ////////////////////

  // HTRANS codes as driven on the bus
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  ////////////////////
  // Burst types
  ////////////////////

  typedef logic [2:0] hburstT;

  // Only the incrementing bursts are used here
  localparam hburstT BURST_SINGLE = 3'b000;
  localparam hburstT BURST_INCR   = 3'b001;
  localparam hburstT BURST_INCR4  = 3'b011;
  localparam hburstT BURST_INCR8  = 3'b101;
  localparam hburstT BURST_INCR16 = 3'b111;

  // Bus address and data words
  typedef logic [31:0] ahbAddrT;
  typedef logic [31:0] ahbDataT;

endpackage

// File: rtl/busAddrGen.sv
`timescale 1ns/1ps

module busAddrGen
  import ahbPkg::*;
  import lsuPkg::*;
#(
  parameter int WordsPerLine = 4,
  localparam int WordIdxW = $clog2(WordsPerLine)
) (
  input  ahbAddrT             uncachedAdr,
  input  ahbAddrT             lineAdr,
  input  logic                selUncachedAdr,
  input  logic [WordIdxW-1:0] wordCount,
  output ahbAddrT             HADDR
);

  // Byte offset bits of one word
  localparam int WordOffW = $bits(wordOffT);
  // Low address bits covered by one line
  localparam ahbAddrT LineMask = ahbAddrT'(WordsPerLine * BYTES_PER_WORD - 1);

  ahbAddrT wordAdr;
  ahbAddrT lineBase;
  ahbAddrT beatOffset;
  ahbAddrT beatAdr;

  ////////////////////
  // Uncached path
  ////////////////////

  // Full-word transfers only
  assign wordAdr = {uncachedAdr[31:WordOffW], wordOffT'(0)};

  ////////////////////
  // Line path
  ////////////////////

  // Start of the line regardless of where the cache pointed
  assign lineBase = lineAdr & ~LineMask;

  // Byte offset of the beat now in its address phase
  assign beatOffset = ahbAddrT'(wordCount) * BYTES_PER_WORD;

  assign beatAdr = lineBase + beatOffset;

  assign HADDR = selUncachedAdr ? wordAdr : beatAdr;

endmodule

// File: rtl/busCacheFsm.sv
`timescale 1ns/1ps

module busCacheFsm
  import ahbPkg::*;
  import lsuPkg::*;
#(
  parameter int WordsPerLine = 4,
  localparam int WordIdxW = $clog2(WordsPerLine)
) (
  input  logic                HCLK,
  input  logic                HRESETn,
  // Core side
  input  memRwT               rw,
  input  logic                cpuBusy,
  output logic                busStall,
  output logic                busCommitted,
  // Cache controller side
  input  memRwT               cacheRw,
  output logic                cacheBusAck,
  // Datapath controls
  output logic                captureEn,
  output logic                captureLine,
  output logic                selUncachedAdr,
  output logic                selBusWord,
  output logic [WordIdxW-1:0] wordCount,
  output logic [WordIdxW-1:0] wordCountDelayed,
  // AHB control
  input  logic                HREADY,
  output htransT              HTRANS,
  output logic                HWRITE,
  output hburstT              HBURST
);

  typedef enum logic [2:0] {
    READY,
    CAPTURE,
    DELAY,
    CPU_BUSY,
    LINE_ACCESS
  } busStateT;

  // Burst code for a whole line
  localparam hburstT LineBurst = burstFor(WordsPerLine);
  // Index of the final beat of a line
  localparam logic [WordIdxW-1:0] LastBeat = WordIdxW'(WordsPerLine - 1);

  busStateT state;
  busStateT nextState;

  logic cpuReq;
  logic lineReq;
  logic lineStart;
  logic lastBeat;
  logic cntEn;
  logic cntClr;

  assign cpuReq  = |rw;
  assign lineReq = |cacheRw;

  // Core request wins over a pending line request
  assign lineStart = (state == READY) && !cpuReq && lineReq;

  // Data phase of the final beat is on the bus
  assign lastBeat = (wordCountDelayed == LastBeat);

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        // Address phase goes out only while the bus is ready
        if (HREADY && cpuReq) begin
          nextState = CAPTURE;
        end else if (HREADY && lineReq) begin
          nextState = LINE_ACCESS;
        end
      end
      // Single data phase of an uncached word
      CAPTURE: if (HREADY) nextState = DELAY;
      // busStall is already low here
      DELAY: nextState = cpuBusy ? CPU_BUSY : READY;
      CPU_BUSY: if (!cpuBusy) nextState = READY;
      LINE_ACCESS: if (HREADY && lastBeat) nextState = READY;
      default: nextState = READY;
    endcase
  end

  ////////////////////
  // Beat counters
  ////////////////////

  // Advance on each accepted address phase of a line
  assign cntEn  = HREADY && (lineStart || state == LINE_ACCESS);
  assign cntClr = (nextState == READY);

  // wordCount drives the address phase, the delayed copy the data phase
  always_ff @(posedge HCLK) begin
    if (!HRESETn || cntClr) begin
      wordCount        <= '0;
      wordCountDelayed <= '0;
    end else if (cntEn) begin
      wordCount        <= wordCount + 1'b1;
      wordCountDelayed <= wordCount;
    end
  end

  ////////////////////
  // Core and cache status
  ////////////////////

  assign busStall = (state == READY && (cpuReq || lineReq)) ||
                    (state == CAPTURE) ||
                    (state == LINE_ACCESS);

  assign busCommitted = (state != READY);

  // One pulse on the edge that ends the last data phase
  assign cacheBusAck = (state == LINE_ACCESS) && HREADY && lastBeat;

  ////////////////////
  // Datapath selects
  ////////////////////

  // Read data phases only
  assign captureEn = HREADY && ((state == CAPTURE && rw[1]) ||
                                (state == LINE_ACCESS && cacheRw[1]));
  assign captureLine = (state == LINE_ACCESS);

  // Core address held until the uncached access retires
  assign selUncachedAdr = (state == READY && cpuReq) ||
                          (state == CAPTURE) ||
                          (state == DELAY) ||
                          (state == CPU_BUSY);

  // High picks the line word, low the core's store word
  assign selBusWord = lineStart || (state == LINE_ACCESS);

  ////////////////////
  // AHB control
  ////////////////////

  always_comb begin
    HTRANS = IDLE;
    if (state == READY && HREADY && (cpuReq || lineReq)) begin
      HTRANS = NONSEQ;
    end else if (state == LINE_ACCESS && wordCount != '0) begin
      // Counter wraps to zero once every beat has been issued
      HTRANS = SEQ;
    end
  end

  always_comb begin
    HWRITE = 1'b0;
    if (state == READY) begin
      HWRITE = cpuReq ? rw[0] : (lineReq && cacheRw[0]);
    end else if (state == LINE_ACCESS) begin
      HWRITE = cacheRw[0];
    end
  end

  // Uncached words always go out as SINGLE
  assign HBURST = (lineStart || state == LINE_ACCESS) ? LineBurst : BURST_SINGLE;

endmodule

// File: rtl/busCaptureBuf.sv
`timescale 1ns/1ps

module busCaptureBuf
  import ahbPkg::*;
#(
  parameter int WordsPerLine = 4,
  localparam int WordIdxW = $clog2(WordsPerLine)
) (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        captureEn,
  input  logic                        captureLine,
  input  logic [WordIdxW-1:0]         wordCountDelayed,
  input  ahbDataT                     HRDATA,
  output ahbDataT [WordsPerLine-1:0]  fetchedLine,
  output ahbDataT                     readData
);

  logic lineWrEn;
  logic wordWrEn;

  // Split the single capture strobe by access kind
  assign lineWrEn = captureEn && captureLine;
  assign wordWrEn = captureEn && !captureLine;

  ////////////////////
  // Line buffer
  ////////////////////

  // One slot per beat, indexed by the data phase counter
  always_ff @(posedge HCLK) begin
    if (lineWrEn) begin
      fetchedLine[wordCountDelayed] <= HRDATA;
    end
  end

  ////////////////////
  // Uncached word
  ////////////////////

  // Holds until the next uncached read
  // keeps the core's operand steady while it is frozen
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      readData <= '0;
    end else if (wordWrEn) begin
      readData <= HRDATA;
    end
  end

endmodule

// File: rtl/busWriteStage.sv
`timescale 1ns/1ps

module busWriteStage
  import ahbPkg::*;
#(
  parameter int WordsPerLine = 4,
  localparam int WordIdxW = $clog2(WordsPerLine)
) (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        HREADY,
  input  logic                        selBusWord,
  input  ahbDataT                     storeData,
  input  ahbDataT [WordsPerLine-1:0]  lineWriteData,
  input  logic [WordIdxW-1:0]         wordCount,
  output ahbDataT                     HWDATA
);

  ahbDataT lineWord;
  ahbDataT nextWord;

  ////////////////////
  // Word select
  ////////////////////

  // Line word for the beat in its address phase
  assign lineWord = lineWriteData[wordCount];

  assign nextWord = selBusWord ? lineWord : storeData;

  ////////////////////
  // Data phase register
  ////////////////////

  // Loads on the edge that accepts the address phase
  // so the word appears one cycle later with its data phase
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      HWDATA <= '0;
    end else if (HREADY) begin
      HWDATA <= nextWord;
    end
    // Wait states keep the current word on the bus
  end

endmodule

// File: rtl/lsuBusIf.sv
`timescale 1ns/1ps

module lsuBusIf
  import ahbPkg::*;
  import lsuPkg::*;
#(
  parameter int WordsPerLine = 4
) (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  // Core memory stage
  input  memRwT                       rw,
  input  logic                        cpuBusy,
  input  ahbAddrT                     uncachedAdr,
  input  ahbDataT                     storeData,
  output ahbDataT                     readData,
  output logic                        busStall,
  output logic                        busCommitted,
  // Cache controller
  input  memRwT                       cacheRw,
  input  ahbAddrT                     lineAdr,
  input  ahbDataT [WordsPerLine-1:0]  lineWriteData,
  output ahbDataT [WordsPerLine-1:0]  fetchedLine,
  output logic                        cacheBusAck,
  // AHB-Lite master port
  input  logic                        HREADY,
  input  ahbDataT                     HRDATA,
  output ahbAddrT                     HADDR,
  output htransT                      HTRANS,
  output logic                        HWRITE,
  output hburstT                      HBURST,
  output ahbDataT                     HWDATA
);

  localparam int WordIdxW = $clog2(WordsPerLine);

  // Address phase and data phase beat indices
  logic [WordIdxW-1:0] wordCount;
  logic [WordIdxW-1:0] wordCountDelayed;

  logic selUncachedAdr;
  logic selBusWord;
  logic captureEn;
  logic captureLine;

  ////////////////////
  // Control
  ////////////////////

  busCacheFsm #(
    .WordsPerLine(WordsPerLine)
  ) i_fsm (
    .HCLK             (HCLK),
    .HRESETn          (HRESETn),
    .rw               (rw),
    .cpuBusy          (cpuBusy),
    .busStall         (busStall),
    .busCommitted     (busCommitted),
    .cacheRw          (cacheRw),
    .cacheBusAck      (cacheBusAck),
    .captureEn        (captureEn),
    .captureLine      (captureLine),
    .selUncachedAdr   (selUncachedAdr),
    .selBusWord       (selBusWord),
    .wordCount        (wordCount),
    .wordCountDelayed (wordCountDelayed),
    .HREADY           (HREADY),
    .HTRANS           (HTRANS),
    .HWRITE           (HWRITE),
    .HBURST           (HBURST)
  );

  ////////////////////
  // Datapath
  ////////////////////

  busAddrGen #(
    .WordsPerLine(WordsPerLine)
  ) i_addrGen (
    .uncachedAdr    (uncachedAdr),
    .lineAdr        (lineAdr),
    .selUncachedAdr (selUncachedAdr),
    .wordCount      (wordCount),
    .HADDR          (HADDR)
  );

  busWriteStage #(
    .WordsPerLine(WordsPerLine)
  ) i_writeStage (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .HREADY        (HREADY),
    .selBusWord    (selBusWord),
    .storeData     (storeData),
    .lineWriteData (lineWriteData),
    .wordCount     (wordCount),
    .HWDATA        (HWDATA)
  );

  // Read side uses the data phase index
  busCaptureBuf #(
    .WordsPerLine(WordsPerLine)
  ) i_captureBuf (
    .HCLK             (HCLK),
    .HRESETn          (HRESETn),
    .captureEn        (captureEn),
    .captureLine      (captureLine),
    .wordCountDelayed (wordCountDelayed),
    .HRDATA           (HRDATA),
    .fetchedLine      (fetchedLine),
    .readData         (readData)
  );

endmodule

// File: rtl/lsuPkg.sv
package lsuPkg;

  import ahbPkg::*;

  // Request code, bit 1 reads and bit 0 writes
  // All zero means no request pending
  typedef logic [1:0] memRwT;

  // Every transfer is one full bus word
  localparam int BYTES_PER_WORD = 4;

  // Byte offset inside one word
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] wordOffT;

  ////////////////////
  // Burst selection
  ////////////////////

  // Fixed-length burst where AHB has one, open INCR otherwise
  function automatic hburstT burstFor(input int wordsPerLine);
    hburstT burst;
    case (wordsPerLine)
      4:       burst = BURST_INCR4;
      8:       burst = BURST_INCR8;
      16:      burst = BURST_INCR16;
      default: burst = BURST_INCR;
    endcase
    return burst;
  endfunction

endpackage

// File: sim/ahbMemModel.sv
`timescale 1ns/1ps

module ahbMemModel
  import ahbPkg::*;
#(
  parameter int LogDepth = 1024
) (
  input  logic       HCLK,
  input  logic       HRESETn,
  input  ahbAddrT    HADDR,
  input  htransT     HTRANS,
  input  logic       HWRITE,
  input  hburstT     HBURST,
  input  ahbDataT    HWDATA,
  // Wait states for the next accepted address phase
  input  logic [1:0] waitSel,
  output logic       HREADY,
  output ahbDataT    HRDATA,
  output logic       holdErr
);

  // 256 words, byte address bits 9:2
  ahbDataT mem [256];

  // One log entry per accepted address phase
  ahbAddrT logAddr  [LogDepth];
  htransT  logTrans [LogDepth];
  hburstT  logBurst [LogDepth];
  logic    logWrite [LogDepth];
  int      beatCnt;

  // Data phase in flight
  logic       pending;
  logic       pendWrite;
  logic [7:0] pendIdx;
  logic [1:0] waitLeft;

  // Bus values seen in the previous cycle
  ahbAddrT prevAddr;
  htransT  prevTrans;
  ahbDataT prevWdata;
  logic    prevReady;

  assign HREADY = !(pending && waitLeft != 2'd0);
  assign HRDATA = (pending && !pendWrite) ? mem[pendIdx] : '0;

  always @(posedge HCLK) begin
    if (!HRESETn) begin
      pending   <= 1'b0;
      pendWrite <= 1'b0;
      waitLeft  <= 2'd0;
      beatCnt   <= 0;
      holdErr   <= 1'b0;
      prevReady <= 1'b1;
    end else begin
      if (pending && !HREADY) begin
        waitLeft <= waitLeft - 2'd1;
      end
      if (HREADY) begin
        // Data phase completes here
        if (pending && pendWrite) begin
          mem[pendIdx] <= HWDATA;
        end
        pending <= 1'b0;
        // New address phase accepted
        if (HTRANS == NONSEQ || HTRANS == SEQ) begin
          pending   <= 1'b1;
          pendWrite <= HWRITE;
          pendIdx   <= HADDR[9:2];
          waitLeft  <= waitSel;
          logAddr[beatCnt % LogDepth]  <= HADDR;
          logTrans[beatCnt % LogDepth] <= HTRANS;
          logBurst[beatCnt % LogDepth] <= HBURST;
          logWrite[beatCnt % LogDepth] <= HWRITE;
          beatCnt <= beatCnt + 1;
        end
      end
      // Master must hold its outputs through a wait state
      if (!prevReady && (HADDR !== prevAddr || HTRANS !== prevTrans ||
                         HWDATA !== prevWdata)) begin
        holdErr <= 1'b1;
      end
      prevAddr  <= HADDR;
      prevTrans <= HTRANS;
      prevWdata <= HWDATA;
      prevReady <= HREADY;
    end
  end

endmodule

// File: sim/lsuBusIfTb.sv
`timescale 1ns/1ps

module lsuBusIfTb
  import ahbPkg::*;
  import lsuPkg::*;
;

  localparam int WordsPerLine = 4;
  localparam int LogDepth = 1024;
  localparam logic [31:0] Seed = 32'hec49e5dd;

  logic    HCLK;
  logic    HRESETn;
  memRwT   rw;
  logic    cpuBusy;
  ahbAddrT uncachedAdr;
  ahbDataT storeData;
  ahbDataT readData;
  logic    busStall;
  logic    busCommitted;
  memRwT   cacheRw;
  ahbAddrT lineAdr;
  ahbDataT [WordsPerLine-1:0] lineWriteData;
  ahbDataT [WordsPerLine-1:0] fetchedLine;
  logic    cacheBusAck;
  logic    HREADY;
  ahbDataT HRDATA;
  ahbAddrT HADDR;
  htransT  HTRANS;
  logic    HWRITE;
  hburstT  HBURST;
  ahbDataT HWDATA;
  logic    holdErr;

  // Stimulus and wait-state streams
  logic [31:0] lfsr = Seed;
  logic [31:0] waitLfsr = Seed;
  logic [1:0]  waitSel = 2'd0;

  // Expected memory contents
  ahbDataT shadow [256];

  lsuBusIf #(
    .WordsPerLine(WordsPerLine)
  ) i_dut (
    .HCLK(HCLK), .HRESETn(HRESETn), .rw(rw), .cpuBusy(cpuBusy),
    .uncachedAdr(uncachedAdr), .storeData(storeData), .readData(readData),
    .busStall(busStall), .busCommitted(busCommitted), .cacheRw(cacheRw),
    .lineAdr(lineAdr), .lineWriteData(lineWriteData), .fetchedLine(fetchedLine),
    .cacheBusAck(cacheBusAck), .HREADY(HREADY), .HRDATA(HRDATA), .HADDR(HADDR),
    .HTRANS(HTRANS), .HWRITE(HWRITE), .HBURST(HBURST), .HWDATA(HWDATA)
  );

  ahbMemModel #(
    .LogDepth(LogDepth)
  ) i_mem (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HTRANS(HTRANS),
    .HWRITE(HWRITE), .HBURST(HBURST), .HWDATA(HWDATA), .waitSel(waitSel),
    .HREADY(HREADY), .HRDATA(HRDATA), .holdErr(holdErr)
  );

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  ////////////////////
  // Random numbers
  ////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randBits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // 0 to 3 wait states, fresh bits every cycle
  always @(posedge HCLK) begin
    waitLfsr = lfsrStep(waitLfsr);
    waitLfsr = lfsrStep(waitLfsr);
    waitSel <= waitLfsr[1:0];
  end

  // Initial word depends on all address bits
  function automatic ahbDataT fillWord(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
  endfunction

  ////////////////////
  // Checks and waits
  ////////////////////

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic failTimeout(input string what);
    $display("Timeout after 200 cycles waiting for %s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic waitStallLow();
    int cycles;
    cycles = 0;
    @(negedge HCLK);
    while (busStall) begin
      cycles++;
      if (cycles == 200) failTimeout("busStall to fall");
      @(negedge HCLK);
    end
  endtask

  task automatic waitAck();
    int cycles;
    cycles = 0;
    @(negedge HCLK);
    while (!cacheBusAck) begin
      cycles++;
      if (cycles == 200) failTimeout("cacheBusAck");
      @(negedge HCLK);
    end
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    @(negedge HCLK);
    while (busCommitted) begin
      cycles++;
      if (cycles == 200) failTimeout("busCommitted to fall");
      @(negedge HCLK);
    end
  endtask

  // Beats logged by the slave since start
  task automatic checkBeats(input int start, input int count, input ahbAddrT base,
                            input hburstT burst, input logic write);
    int k;
    int idx;
    checkEq("beat count", i_mem.beatCnt - start, count);
    for (k = 0; k < count; k++) begin
      idx = (start + k) % LogDepth;
      checkEq("HADDR", i_mem.logAddr[idx], base + 4 * k);
      checkEq("HTRANS", i_mem.logTrans[idx], (k == 0) ? NONSEQ : SEQ);
      checkEq("HBURST", i_mem.logBurst[idx], burst);
      checkEq("HWRITE", i_mem.logWrite[idx], write);
    end
  endtask

  ////////////////////
  // Request drivers
  ////////////////////

  task automatic cpuRead(input ahbAddrT addr, input int hold);
    ahbDataT held;
    @(posedge HCLK);
    uncachedAdr <= addr;
    rw          <= 2'b10;
    cpuBusy     <= (hold != 0);
    waitStallLow();
    held = readData;
    checkEq("readData", held, shadow[addr[9:2]]);
    // Core frozen, word must not move
    repeat (hold) begin
      @(negedge HCLK);
      checkEq("readData", readData, held);
      checkEq("busCommitted", busCommitted, 1'b1);
    end
    @(posedge HCLK);
    rw      <= 2'b00;
    cpuBusy <= 1'b0;
    waitIdle();
    checkEq("readData", readData, held);
  endtask

  task automatic cpuWrite(input ahbAddrT addr, input ahbDataT data);
    int start;
    start = i_mem.beatCnt;
    @(posedge HCLK);
    uncachedAdr <= addr;
    storeData   <= data;
    rw          <= 2'b01;
    cpuBusy     <= 1'b0;
    waitStallLow();
    @(posedge HCLK);
    rw <= 2'b00;
    waitIdle();
    shadow[addr[9:2]] = data;
    checkBeats(start, 1, addr, BURST_SINGLE, 1'b1);
  endtask

  // Fill when words is unused, writeback otherwise
  task automatic lineAccess(input logic [5:0] lineIdx, input logic isWrite,
                            input ahbDataT [WordsPerLine-1:0] words);
    int start;
    int k;
    logic [31:0] off;
    ahbAddrT base;
    start = i_mem.beatCnt;
    base = ahbAddrT'(lineIdx) << 4;
    randBits(2, off);
    @(posedge HCLK);
    // Any word inside the line, the DUT aligns it
    lineAdr       <= base | (off << 2);
    lineWriteData <= words;
    cacheRw       <= isWrite ? 2'b01 : 2'b10;
    waitAck();
    @(posedge HCLK);
    cacheRw <= 2'b00;
    @(negedge HCLK);
    checkEq("cacheBusAck", cacheBusAck, 1'b0);
    for (k = 0; k < WordsPerLine; k++) begin
      if (isWrite) begin
        shadow[{lineIdx, 2'(k)}] = words[k];
      end else begin
        checkEq("fetchedLine", fetchedLine[k], shadow[{lineIdx, 2'(k)}]);
      end
    end
    checkBeats(start, WordsPerLine, base, BURST_INCR4, isWrite);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int op;
    int i;
    logic [31:0] kind;
    logic [31:0] wIdx;
    logic [31:0] lIdx;
    logic [31:0] data;
    logic [31:0] hold;
    ahbDataT [WordsPerLine-1:0] words;
    HRESETn       = 1'b0;
    rw            = 2'b00;
    cpuBusy       = 1'b0;
    uncachedAdr   = '0;
    storeData     = '0;
    cacheRw       = 2'b00;
    lineAdr       = '0;
    lineWriteData = '0;
    for (i = 0; i < 256; i++) begin
      shadow[i]     = fillWord(8'(i));
      i_mem.mem[i]  = fillWord(8'(i));
    end
    repeat (4) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    checkEq("HTRANS", HTRANS, IDLE);
    checkEq("HWRITE", HWRITE, 1'b0);
    checkEq("busStall", busStall, 1'b0);
    checkEq("busCommitted", busCommitted, 1'b0);
    checkEq("cacheBusAck", cacheBusAck, 1'b0);

    for (op = 0; op < 60; op++) begin
      randBits(2, kind);
      randBits(8, wIdx);
      randBits(6, lIdx);
      randBits(32, data);
      randBits(2, hold);
      for (i = 0; i < WordsPerLine; i++) begin
        randBits(32, words[i]);
      end
      case (kind[1:0])
        2'd0: cpuRead({wIdx[29:0], 2'b00}, hold);
        2'd1: begin
          cpuWrite({wIdx[29:0], 2'b00}, data);
          cpuRead({wIdx[29:0], 2'b00}, 0);
        end
        2'd2: lineAccess(lIdx[5:0], 1'b0, words);
        default: begin
          lineAccess(lIdx[5:0], 1'b1, words);
          lineAccess(lIdx[5:0], 1'b0, words);
        end
      endcase
      checkEq("holdErr", holdErr, 1'b0);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: verilog.f
rtl/ahbPkg.sv
rtl/lsuPkg.sv
rtl/busCacheFsm.sv
rtl/busAddrGen.sv
rtl/busWriteStage.sv
rtl/busCaptureBuf.sv
rtl/lsuBusIf.sv
sim/ahbMemModel.sv
sim/lsuBusIfTb.sv
